// ==== harness_pkg.sv ====
package harness_pkg;

  localparam int unsigned APB_AW = 32;
  localparam int unsigned APB_DW = 32;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam logic [APB_AW-1:0] ROM_BASE  = 32'h0000_1000;
  localparam logic [APB_AW-1:0] ROM_LEN   = 32'h0000_1000;
  localparam logic [APB_AW-1:0] CTRL_BASE = 32'h0000_2000;
  localparam logic [APB_AW-1:0] CTRL_LEN  = 32'h0000_0100;
  // SRAM window length comes from the depth set at the top
  localparam logic [APB_AW-1:0] SRAM_BASE = 32'h8000_0000;

  // Boot image, repeats every 16 words inside the ROM window
  localparam int unsigned ROM_WORDS = 16;
  localparam logic [APB_DW-1:0] BOOT_IMAGE [ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8593, 32'hF140_2573, 32'h0182_B283,
    32'h0002_8067, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h8000_0000, 32'h0000_0000, 32'h1050_0073, 32'hFFDF_F06F,
    32'hDEAD_BEEF, 32'hCAFE_F00D, 32'h0123_4567, 32'h89AB_CDEF
  };

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_CTRL,
    TGT_SRAM,
    TGT_NONE
  } target_e;

  // Offsets inside the control window
  typedef enum logic [7:0] {
    REG_CTRL     = 8'h00,
    REG_EXIT     = 8'h04,
    REG_RD_BEATS = 8'h08,
    REG_WR_BEATS = 8'h0C
  } reg_addr_e;

endpackage

// ==== apb_decoder.sv ====
`timescale 1ns/100ps

module apb_decoder import harness_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [APB_AW-1:0]   paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [APB_DW-1:0]   pwdata_i,
  input  logic [APB_DW/8-1:0] pstrb_i,
  output logic [APB_DW-1:0]   prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output logic                sel_rom_o,
  output logic                sel_ctrl_o,
  output logic                sel_sram_o,
  input  logic [APB_DW-1:0]   rom_rdata_i,
  input  logic                rom_slverr_i,
  input  logic [APB_DW-1:0]   ctrl_rdata_i,
  input  logic                ctrl_slverr_i,
  input  logic [APB_DW-1:0]   sram_rdata_i,
  input  logic                sram_slverr_i
);

  localparam logic [APB_AW-1:0] SRAM_LEN = APB_AW'(NumWords * (APB_DW / 8));

  target_e tgt_d, tgt_q, tgt_sel;
  logic    access;

  function automatic target_e decode(input logic [APB_AW-1:0] addr);
    target_e tgt;
    tgt = TGT_NONE;
    if (addr >= ROM_BASE && addr < ROM_BASE + ROM_LEN) begin
      tgt = TGT_ROM;
    end else if (addr >= CTRL_BASE && addr < CTRL_BASE + CTRL_LEN) begin
      tgt = TGT_CTRL;
    end else if (addr >= SRAM_BASE && addr < SRAM_BASE + SRAM_LEN) begin
      tgt = TGT_SRAM;
    end
    return tgt;
  endfunction

  assign tgt_d  = decode(paddr_i);
  assign access = psel_i & penable_i;

  // Target is captured in setup and held for the access cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q <= TGT_NONE;
    end else if (psel_i && !penable_i) begin
      tgt_q <= tgt_d;
    end
  end

  assign tgt_sel = penable_i ? tgt_q : tgt_d;

  assign sel_rom_o  = psel_i && (tgt_sel == TGT_ROM);
  assign sel_ctrl_o = psel_i && (tgt_sel == TGT_CTRL);
  assign sel_sram_o = psel_i && (tgt_sel == TGT_SRAM);

  // All targets answer in the access cycle
  assign pready_o = 1'b1;

  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    case (tgt_sel)
      TGT_ROM: begin
        prdata_o  = rom_rdata_i;
        pslverr_o = access & rom_slverr_i;
      end
      TGT_CTRL: begin
        prdata_o  = ctrl_rdata_i;
        pslverr_o = access & ctrl_slverr_i;
      end
      TGT_SRAM: begin
        prdata_o  = sram_rdata_i;
        pslverr_o = access & sram_slverr_i;
      end
      default: pslverr_o = access;
    endcase
  end

endmodule

// ==== boot_rom.sv ====
`timescale 1ns/100ps

module boot_rom import harness_pkg::*; (
  input  logic              sel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_AW-1:0] paddr_i,
  output logic [APB_DW-1:0] rdata_o,
  output logic              slverr_o
);

  localparam int unsigned IdxW   = $clog2(ROM_WORDS);
  localparam int unsigned OffLsb = $clog2(APB_DW / 8);

  logic [IdxW-1:0] word_idx;

  // Word offset modulo the image size, window base is aligned
  assign word_idx = paddr_i[OffLsb +: IdxW];

  assign rdata_o = (sel_i && !pwrite_i) ? BOOT_IMAGE[word_idx] : '0;

  // Read-only, writes are refused
  assign slverr_o = sel_i & penable_i & pwrite_i;

endmodule

// ==== apb_sram.sv ====
`timescale 1ns/100ps

module apb_sram import harness_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                sys_rst_ni,
  input  logic                sel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [APB_AW-1:0]   paddr_i,
  input  logic [APB_DW-1:0]   pwdata_i,
  input  logic [APB_DW/8-1:0] pstrb_i,
  output logic [APB_DW-1:0]   rdata_o,
  output logic                slverr_o,
  output logic [31:0]         rd_beats_o,
  output logic [31:0]         wr_beats_o
);

  localparam int unsigned StrbW  = APB_DW / 8;
  localparam int unsigned IdxW   = $clog2(NumWords);
  localparam int unsigned OffLsb = $clog2(StrbW);

  logic [APB_DW-1:0] mem_q [NumWords];
  logic [IdxW-1:0]   word_idx;
  logic              rd_en;
  logic              wr_en;
  logic              cnt_rst_n;
  logic [31:0]       rd_beats_q;
  logic [31:0]       wr_beats_q;

  assign word_idx = paddr_i[OffLsb +: IdxW];
  assign rd_en    = sel_i & penable_i & ~pwrite_i;
  assign wr_en    = sel_i & penable_i & pwrite_i;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < StrbW; b++) begin
        if (pstrb_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o  = mem_q[word_idx];
  assign slverr_o = 1'b0;

  // --------------------------------------------------------------------------
  // Beat counters
  // --------------------------------------------------------------------------
  // Cleared by power-on reset as well as by a requested system reset
  assign cnt_rst_n = rst_ni & sys_rst_ni;

  always_ff @(posedge clk_i or negedge cnt_rst_n) begin
    if (!cnt_rst_n) begin
      rd_beats_q <= '0;
      wr_beats_q <= '0;
    end else begin
      if (rd_en) begin
        rd_beats_q <= rd_beats_q + 32'd1;
      end
      if (wr_en) begin
        wr_beats_q <= wr_beats_q + 32'd1;
      end
    end
  end

  assign rd_beats_o = rd_beats_q;
  assign wr_beats_o = wr_beats_q;

endmodule

// ==== harness_regs.sv ====
`timescale 1ns/100ps

module harness_regs import harness_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              sel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic [APB_DW-1:0] pwdata_i,
  input  logic [31:0]       rd_beats_i,
  input  logic [31:0]       wr_beats_i,
  output logic [APB_DW-1:0] rdata_o,
  output logic              slverr_o,
  output logic              ndmreset_req_o,
  output logic              debug_en_o,
  output logic [31:0]       exit_o
);

  reg_addr_e   reg_addr;
  logic        access;
  logic        err;
  logic        wr_ctrl;
  logic        wr_exit;
  logic        rst_req_q;
  logic        debug_en_q;
  logic [31:0] exit_q;

  assign reg_addr = reg_addr_e'(paddr_i[7:0]);
  assign access   = sel_i & penable_i;

  // --------------------------------------------------------------------------
  // Offset decode and read mux
  // --------------------------------------------------------------------------
  always_comb begin
    rdata_o = '0;
    err     = 1'b0;
    wr_ctrl = 1'b0;
    wr_exit = 1'b0;
    case (reg_addr)
      REG_CTRL: begin
        rdata_o = {{(APB_DW-2){1'b0}}, debug_en_q, rst_req_q};
        wr_ctrl = pwrite_i;
      end
      REG_EXIT: begin
        rdata_o = exit_q;
        wr_exit = pwrite_i;
      end
      // Beat counters are read-only
      REG_RD_BEATS: begin
        rdata_o = rd_beats_i;
        err     = pwrite_i;
      end
      REG_WR_BEATS: begin
        rdata_o = wr_beats_i;
        err     = pwrite_i;
      end
      default: err = 1'b1;
    endcase
  end

  assign slverr_o = access & err;

  // --------------------------------------------------------------------------
  // Registers, kept on power-on reset only
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_req_q  <= 1'b0;
      debug_en_q <= 1'b1;
      exit_q     <= '0;
    end else begin
      if (access && wr_ctrl) begin
        rst_req_q  <= pwdata_i[0];
        debug_en_q <= pwdata_i[1];
      end
      if (access && wr_exit) begin
        exit_q <= pwdata_i;
      end
    end
  end

  assign ndmreset_req_o = rst_req_q;
  assign debug_en_o     = debug_en_q;
  assign exit_o         = exit_q;

endmodule

// ==== debug_reset_ctrl.sv ====
`timescale 1ns/100ps

module debug_reset_ctrl #(
  parameter int unsigned DmiDelCycles = 20
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_req_i,
  input  logic debug_en_i,
  input  logic debug_req_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntW = $clog2(DmiDelCycles + 1);

  logic            comb_rst_n;
  logic [1:0]      sync_q;
  logic [CntW-1:0] del_cnt_q;

  // --------------------------------------------------------------------------
  // System reset
  // --------------------------------------------------------------------------
  // Asserts at once, releases through two flops
  assign comb_rst_n = rst_ni & ~ndmreset_req_i;

  always_ff @(posedge clk_i or negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // --------------------------------------------------------------------------
  // Debug start-up window
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntW'(DmiDelCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  // Gated while the window runs or debug is off
  assign debug_req_o = (del_cnt_q == '0) && debug_en_i && debug_req_i;

endmodule

// ==== harness_top.sv ====
`timescale 1ns/100ps

module harness_top import harness_pkg::*; #(
  parameter int unsigned NumWords     = 256,
  parameter int unsigned DmiDelCycles = 20
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [APB_AW-1:0]   paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [APB_DW-1:0]   pwdata_i,
  input  logic [APB_DW/8-1:0] pstrb_i,
  output logic [APB_DW-1:0]   prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  input  logic                debug_req_i,
  output logic                debug_req_o,
  output logic [31:0]         exit_o
);

  logic              sel_rom;
  logic              sel_ctrl;
  logic              sel_sram;
  logic [APB_DW-1:0] rom_rdata;
  logic              rom_slverr;
  logic [APB_DW-1:0] ctrl_rdata;
  logic              ctrl_slverr;
  logic [APB_DW-1:0] sram_rdata;
  logic              sram_slverr;
  logic [31:0]       rd_beats;
  logic [31:0]       wr_beats;
  logic              ndmreset_req;
  logic              debug_en;
  logic              sys_rst_n;

  // --------------------------------------------------------------------------
  // Bus decode
  // --------------------------------------------------------------------------
  apb_decoder #(
    .NumWords ( NumWords )
  ) i_apb_decoder (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .paddr_i       ( paddr_i     ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .pwdata_i      ( pwdata_i    ),
    .pstrb_i       ( pstrb_i     ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   ),
    .sel_rom_o     ( sel_rom     ),
    .sel_ctrl_o    ( sel_ctrl    ),
    .sel_sram_o    ( sel_sram    ),
    .rom_rdata_i   ( rom_rdata   ),
    .rom_slverr_i  ( rom_slverr  ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .ctrl_slverr_i ( ctrl_slverr ),
    .sram_rdata_i  ( sram_rdata  ),
    .sram_slverr_i ( sram_slverr )
  );

  // --------------------------------------------------------------------------
  // Targets
  // --------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .sel_i     ( sel_rom    ),
    .penable_i ( penable_i  ),
    .pwrite_i  ( pwrite_i   ),
    .paddr_i   ( paddr_i    ),
    .rdata_o   ( rom_rdata  ),
    .slverr_o  ( rom_slverr )
  );

  apb_sram #(
    .NumWords ( NumWords )
  ) i_apb_sram (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .sys_rst_ni ( sys_rst_n   ),
    .sel_i      ( sel_sram    ),
    .penable_i  ( penable_i   ),
    .pwrite_i   ( pwrite_i    ),
    .paddr_i    ( paddr_i     ),
    .pwdata_i   ( pwdata_i    ),
    .pstrb_i    ( pstrb_i     ),
    .rdata_o    ( sram_rdata  ),
    .slverr_o   ( sram_slverr ),
    .rd_beats_o ( rd_beats    ),
    .wr_beats_o ( wr_beats    )
  );

  harness_regs i_harness_regs (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .sel_i          ( sel_ctrl     ),
    .penable_i      ( penable_i    ),
    .pwrite_i       ( pwrite_i     ),
    .paddr_i        ( paddr_i      ),
    .pwdata_i       ( pwdata_i     ),
    .rd_beats_i     ( rd_beats     ),
    .wr_beats_i     ( wr_beats     ),
    .rdata_o        ( ctrl_rdata   ),
    .slverr_o       ( ctrl_slverr  ),
    .ndmreset_req_o ( ndmreset_req ),
    .debug_en_o     ( debug_en     ),
    .exit_o         ( exit_o       )
  );

  // Reset and debug gating
  debug_reset_ctrl #(
    .DmiDelCycles ( DmiDelCycles )
  ) i_debug_reset_ctrl (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .ndmreset_req_i ( ndmreset_req ),
    .debug_en_i     ( debug_en     ),
    .debug_req_i    ( debug_req_i  ),
    .sys_rst_no     ( sys_rst_n    ),
    .debug_req_o    ( debug_req_o  )
  );

endmodule

// ==== tb_apb_tasks.svh ====
// APB requester tasks
// Inputs change on the falling edge and the response is taken at the
// rising edge that completes the access

task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic err);
  int unsigned cycles;
  logic        done;
  cycles = 0;
  done   = 1'b0;
  err    = 1'b0;
  // Setup phase
  @(negedge clk);
  paddr   = addr;
  pwrite  = 1'b1;
  pwdata  = data;
  pstrb   = strb;
  psel    = 1'b1;
  penable = 1'b0;
  // Access phase held until pready
  @(negedge clk);
  penable = 1'b1;
  while (!done && cycles < ApbTimeout) begin
    @(posedge clk);
    cycles++;
    if (pready) begin
      done = 1'b1;
      err  = pslverr;
    end
  end
  if (!done) begin
    $display("APB write to %h got no pready within %0d cycles", addr, ApbTimeout);
    $display("** FAIL **");
    $finish;
  end
  // Zero-wait-state targets answer at the first access edge
  expect_eq(cycles, 32'd1, "APB write completion cycle");
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                        output logic err);
  int unsigned cycles;
  logic        done;
  cycles = 0;
  done   = 1'b0;
  data   = '0;
  err    = 1'b0;
  @(negedge clk);
  paddr   = addr;
  pwrite  = 1'b0;
  psel    = 1'b1;
  penable = 1'b0;
  @(negedge clk);
  penable = 1'b1;
  while (!done && cycles < ApbTimeout) begin
    @(posedge clk);
    cycles++;
    if (pready) begin
      done = 1'b1;
      data = prdata;
      err  = pslverr;
    end
  end
  if (!done) begin
    $display("APB read from %h got no pready within %0d cycles", addr, ApbTimeout);
    $display("** FAIL **");
    $finish;
  end
  expect_eq(cycles, 32'd1, "APB read completion cycle");
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

// ==== tb_harness.sv ====
`timescale 1ns/100ps

module tb_harness import harness_pkg::*; ();

  localparam int unsigned NumWords     = 256;
  localparam int unsigned DmiDelCycles = 20;
  localparam int unsigned ApbTimeout   = 16;

  localparam logic [31:0] CtrlAddr    = CTRL_BASE + 32'(REG_CTRL);
  localparam logic [31:0] ExitAddr    = CTRL_BASE + 32'(REG_EXIT);
  localparam logic [31:0] RdBeatsAddr = CTRL_BASE + 32'(REG_RD_BEATS);
  localparam logic [31:0] WrBeatsAddr = CTRL_BASE + 32'(REG_WR_BEATS);
  localparam logic [31:0] UnmappedAddrs [4] = '{
    32'h0000_0000, 32'h0000_3000, 32'h8000_0400, 32'hFFFF_FFFC
  };

  logic        clk;
  logic        rst_n;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        debug_req_in;
  logic        debug_req_out;
  logic [31:0] exit_code;

  int unsigned checks;
  int unsigned errors;
  int unsigned rd_count;
  int unsigned wr_count;
  logic [31:0] exit_val;
  logic [31:0] sram_model [NumWords];
  int unsigned used_idx [$];

  harness_top #(
    .NumWords     ( NumWords     ),
    .DmiDelCycles ( DmiDelCycles )
  ) dut_i (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .paddr_i     ( paddr         ),
    .psel_i      ( psel          ),
    .penable_i   ( penable       ),
    .pwrite_i    ( pwrite        ),
    .pwdata_i    ( pwdata        ),
    .pstrb_i     ( pstrb         ),
    .prdata_o    ( prdata        ),
    .pready_o    ( pready        ),
    .pslverr_o   ( pslverr       ),
    .debug_req_i ( debug_req_in  ),
    .debug_req_o ( debug_req_out ),
    .exit_o      ( exit_code     )
  );

  always #4 clk = ~clk;

  task automatic expect_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error [%0t] %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Only strobed bytes take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  `include "tb_apb_tasks.svh"

  // --------------------------------------------------------------------------
  // Test sequences
  // --------------------------------------------------------------------------
  task automatic verify_debug_gating();
    logic [31:0] rdata;
    logic        err;
    // Called on the edge that releases reset
    for (int i = 1; i < DmiDelCycles; i++) begin
      @(negedge clk);
      expect_eq(debug_req_out, 1'b0, $sformatf("debug request in window, cycle %0d", i));
    end
    @(negedge clk);
    expect_eq(debug_req_out, 1'b1, "debug request after window");
    debug_req_in = 1'b0;
    @(negedge clk);
    expect_eq(debug_req_out, 1'b0, "debug request follows input low");
    debug_req_in = 1'b1;
    @(negedge clk);
    expect_eq(debug_req_out, 1'b1, "debug request follows input high");
    apb_write(CtrlAddr, 32'h0, 4'hF, err);
    expect_eq(err, 1'b0, "CTRL write error flag");
    expect_eq(debug_req_out, 1'b0, "debug request with debug disabled");
    apb_write(CtrlAddr, 32'h2, 4'hF, err);
    expect_eq(debug_req_out, 1'b1, "debug request with debug enabled again");
    apb_read(CtrlAddr, rdata, err);
    expect_eq(rdata, 32'h2, "CTRL readback");
  endtask

  task automatic read_boot_rom();
    logic [31:0] rdata;
    logic        err;
    for (int k = 0; k < ROM_WORDS; k++) begin
      apb_read(ROM_BASE + 32'(4 * k), rdata, err);
      expect_eq(err, 1'b0, "ROM read error flag");
      expect_eq(rdata, BOOT_IMAGE[k], $sformatf("ROM word %0d", k));
    end
    // Image repeats up the window
    apb_read(ROM_BASE + 32'h0F48, rdata, err);
    expect_eq(rdata, BOOT_IMAGE[2], "ROM word 2 near top of window");
    apb_write(ROM_BASE + 32'h4, 32'hFFFF_FFFF, 4'hF, err);
    expect_eq(err, 1'b1, "ROM write error flag");
    apb_read(ROM_BASE + 32'h4, rdata, err);
    expect_eq(rdata, BOOT_IMAGE[1], "ROM word 1 after refused write");
  endtask

  task automatic exercise_sram();
    int unsigned idx;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [3:0]  strb;
    logic        err;
    // Full words first so that the model starts defined
    for (int i = 0; i < 8; i++) begin
      idx  = $urandom_range(NumWords - 1, 0);
      data = $urandom;
      apb_write(SRAM_BASE + 32'(4 * idx), data, 4'hF, err);
      wr_count++;
      expect_eq(err, 1'b0, "SRAM write error flag");
      sram_model[idx] = data;
      used_idx.push_back(idx);
    end
    for (int i = 0; i < 24; i++) begin
      idx  = used_idx[$urandom_range(used_idx.size() - 1, 0)];
      data = $urandom;
      strb = 4'($urandom);
      apb_write(SRAM_BASE + 32'(4 * idx), data, strb, err);
      wr_count++;
      sram_model[idx] = merge_bytes(sram_model[idx], data, strb);
    end
    foreach (used_idx[i]) begin
      apb_read(SRAM_BASE + 32'(4 * used_idx[i]), rdata, err);
      rd_count++;
      expect_eq(err, 1'b0, "SRAM read error flag");
      expect_eq(rdata, sram_model[used_idx[i]], $sformatf("SRAM word %0d", used_idx[i]));
    end
  endtask

  task automatic probe_error_responses();
    logic [31:0] rdata;
    logic        err;
    foreach (UnmappedAddrs[i]) begin
      apb_read(UnmappedAddrs[i], rdata, err);
      expect_eq(err, 1'b1, $sformatf("unmapped read error flag at %h", UnmappedAddrs[i]));
      expect_eq(rdata, 32'h0, $sformatf("unmapped read data at %h", UnmappedAddrs[i]));
      apb_write(UnmappedAddrs[i], 32'hA5A5_5A5A, 4'hF, err);
      expect_eq(err, 1'b1, $sformatf("unmapped write error flag at %h", UnmappedAddrs[i]));
    end
    apb_write(RdBeatsAddr, 32'h1234, 4'hF, err);
    expect_eq(err, 1'b1, "write to read beat counter");
    apb_write(WrBeatsAddr, 32'h1234, 4'hF, err);
    expect_eq(err, 1'b1, "write to write beat counter");
    apb_read(CTRL_BASE + 32'h10, rdata, err);
    expect_eq(err, 1'b1, "read of unknown register offset");
    apb_write(CTRL_BASE + 32'hFC, 32'h1, 4'hF, err);
    expect_eq(err, 1'b1, "write to unknown register offset");
  endtask

  task automatic write_exit_code();
    logic [31:0] rdata;
    logic        err;
    exit_val = $urandom;
    apb_write(ExitAddr, exit_val, 4'hF, err);
    expect_eq(err, 1'b0, "EXIT write error flag");
    expect_eq(exit_code, exit_val, "exit_o after write");
    apb_read(ExitAddr, rdata, err);
    expect_eq(rdata, exit_val, "EXIT readback");
  endtask

  task automatic reset_beat_counters();
    logic [31:0] rdata;
    logic        err;
    apb_read(RdBeatsAddr, rdata, err);
    expect_eq(rdata, rd_count, "read beat count");
    apb_read(WrBeatsAddr, rdata, err);
    expect_eq(rdata, wr_count, "write beat count");
    // Reset request with debug left enabled
    apb_write(CtrlAddr, 32'h3, 4'hF, err);
    apb_read(RdBeatsAddr, rdata, err);
    expect_eq(rdata, 32'h0, "read beat count during system reset");
    apb_write(CtrlAddr, 32'h2, 4'hF, err);
    rd_count = 0;
    wr_count = 0;
    apb_read(RdBeatsAddr, rdata, err);
    expect_eq(rdata, 32'h0, "read beat count after system reset");
    apb_read(WrBeatsAddr, rdata, err);
    expect_eq(rdata, 32'h0, "write beat count after system reset");
    apb_read(CtrlAddr, rdata, err);
    expect_eq(rdata, 32'h2, "CTRL after system reset");
    expect_eq(debug_req_out, 1'b1, "debug request after system reset");
    apb_read(ExitAddr, rdata, err);
    expect_eq(rdata, exit_val, "EXIT after system reset");
    expect_eq(exit_code, exit_val, "exit_o after system reset");
    apb_read(SRAM_BASE + 32'(4 * used_idx[0]), rdata, err);
    rd_count++;
    expect_eq(rdata, sram_model[used_idx[0]], "SRAM data after system reset");
    apb_read(RdBeatsAddr, rdata, err);
    expect_eq(rdata, rd_count, "read beat count resumes");
  endtask

  initial begin
    void'($urandom(35682));
    clk          = 1'b0;
    rst_n        = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    pstrb        = '0;
    debug_req_in = 1'b1;
    checks       = 0;
    errors       = 0;
    rd_count     = 0;
    wr_count     = 0;
    repeat (4) @(negedge clk);
    expect_eq(exit_code, 32'h0, "exit_o in reset");
    expect_eq(debug_req_out, 1'b0, "debug_req_o in reset");
    expect_eq(pslverr, 1'b0, "pslverr_o in reset");
    rst_n = 1'b1;
    verify_debug_gating();
    read_boot_rom();
    exercise_sram();
    probe_error_responses();
    write_exit_code();
    reset_beat_counters();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
harness_pkg.sv
apb_decoder.sv
boot_rom.sv
apb_sram.sv
harness_regs.sv
debug_reset_ctrl.sv
harness_top.sv
tb_harness.sv
